// ==== design/drbe_cfg_pkg.sv ====
package drbe_cfg_pkg;

	//////////////////////////////////////////////////
	// Array sizing defaults
	//////////////////////////////////////////////////

	localparam int N_LANES  = 4;
	localparam int N_SAMPLE = 16;

	// One I or Q component
	localparam int DATAWIDTH = 16;

	// Field widths
	localparam int SADDR_W = 8;
	localparam int DEST_W  = 8;
	localparam int ID_W    = 4;

	//////////////////////////////////////////////////
	// Width types
	//////////////////////////////////////////////////

	// I in the upper half, Q in the lower half
	typedef logic [2*DATAWIDTH-1:0] sample_t;

	// Limits a lane to 256 samples
	typedef logic [SADDR_W-1:0] saddr_t;

	typedef logic [DEST_W-1:0] dest_t;

	// Limits the array to 16 lanes
	typedef logic [ID_W-1:0] lc_id_t;

endpackage

// ==== design/drbe_pkt_pkg.sv ====
package drbe_pkt_pkg;

	typedef enum logic {
		CMD_STREAM   = 1'b0,
		CMD_PREFETCH = 1'b1
	} cmd_kind_e;

	typedef enum logic {
		PKT_STREAM   = 1'b0,
		PKT_PREFETCH = 1'b1
	} pkt_kind_e;

	//////////////////////////////////////////////////
	// Packet layout, kind in the top bit
	//////////////////////////////////////////////////

	localparam int PKT_SAMPLE_LSB = 0;
	localparam int PKT_DEST_LSB   = PKT_SAMPLE_LSB + $bits(drbe_cfg_pkg::sample_t);
	localparam int PKT_ID_LSB     = PKT_DEST_LSB + $bits(drbe_cfg_pkg::dest_t);
	localparam int PKT_KIND_BIT   = PKT_ID_LSB + $bits(drbe_cfg_pkg::lc_id_t);
	localparam int PKT_W          = PKT_KIND_BIT + 1;

	typedef logic [PKT_W-1:0] packet_t;

	function automatic packet_t make_packet(
		input pkt_kind_e             kind,
		input drbe_cfg_pkg::lc_id_t  id,
		input drbe_cfg_pkg::dest_t   dest,
		input drbe_cfg_pkg::sample_t sample
	);
		return {kind, id, dest, sample};
	endfunction

	// Field extraction
	function automatic pkt_kind_e pkt_kind(input packet_t p);
		return pkt_kind_e'(p[PKT_KIND_BIT]);
	endfunction

	function automatic drbe_cfg_pkg::lc_id_t pkt_id(input packet_t p);
		return p[PKT_ID_LSB +: $bits(drbe_cfg_pkg::lc_id_t)];
	endfunction

	function automatic drbe_cfg_pkg::dest_t pkt_dest(input packet_t p);
		return p[PKT_DEST_LSB +: $bits(drbe_cfg_pkg::dest_t)];
	endfunction

	function automatic drbe_cfg_pkg::sample_t pkt_sample(input packet_t p);
		return p[PKT_SAMPLE_LSB +: $bits(drbe_cfg_pkg::sample_t)];
	endfunction

endpackage

// ==== design/sample_ram.sv ====
`timescale 1ns/1ps

module sample_ram #(
	parameter int n_sample = drbe_cfg_pkg::N_SAMPLE
) (
	input  logic                  CLK,
	input  logic                  we,
	input  drbe_cfg_pkg::saddr_t  addr,
	input  drbe_cfg_pkg::sample_t wdata,
	input  logic                  re,
	output drbe_cfg_pkg::sample_t rdata
);
	import drbe_cfg_pkg::*;

	localparam int AW = (n_sample > 1) ? $clog2(n_sample) : 1;

	sample_t        mem [0:n_sample-1];
	logic [AW-1:0]  idx;
	logic           in_range;

	assign idx      = addr[AW-1:0];
	assign in_range = (addr < n_sample);

	// Out of range writes are ignored
	always_ff @(posedge CLK) begin
		if (we && in_range) begin
			mem[idx] <= wdata;
		end
	end

	// Read data holds until the next read
	always_ff @(posedge CLK) begin
		if (re) begin
			rdata <= mem[idx];
		end
	end

endmodule

// ==== design/local_controller.sv ====
`timescale 1ns/1ps

module local_controller #(
	parameter int                   n_sample = drbe_cfg_pkg::N_SAMPLE,
	parameter drbe_cfg_pkg::lc_id_t lane_id  = '0
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    load_valid,
	input  drbe_cfg_pkg::saddr_t    load_addr,
	input  drbe_cfg_pkg::sample_t   load_data,
	input  logic                    cmd_valid,
	input  drbe_pkt_pkg::cmd_kind_e cmd_kind,
	input  drbe_cfg_pkg::saddr_t    cmd_start,
	input  drbe_cfg_pkg::saddr_t    cmd_stop,
	input  drbe_cfg_pkg::dest_t     cmd_dest,
	input  logic                    cmd_wait,
	input  logic                    boundary_in,
	input  logic                    take,
	output logic                    pkt_valid,
	output drbe_pkt_pkg::packet_t   pkt,
	output logic                    pkt_last,
	output logic                    boundary_next,
	output logic                    busy
);
	import drbe_cfg_pkg::*;
	import drbe_pkt_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_BOUNDARY,
		READ,
		DRAIN
	} state_e;

	// One bit wider than an address so a full pass of 256 fits
	typedef logic [$bits(saddr_t):0] count_t;

	state_e    state;
	cmd_kind_e kind_q;
	dest_t     dest_q;
	saddr_t    rd_addr;
	count_t    rd_left;
	logic      rd_pend;
	logic      rd_last;
	logic      slot_free;
	logic      rd_en;
	logic      move;
	logic      accept;
	logic      ram_we;
	saddr_t    ram_addr;
	sample_t   ram_rdata;
	pkt_kind_e kind_pkt;

	assign accept    = (state == IDLE) && cmd_valid;
	assign slot_free = !pkt_valid || take;
	assign rd_en     = (state == READ) && slot_free;
	assign move      = rd_pend && slot_free;
	assign busy      = (state != IDLE);
	assign kind_pkt  = (kind_q == CMD_PREFETCH) ? PKT_PREFETCH : PKT_STREAM;

	// Loads own the RAM port while idle
	assign ram_we   = load_valid && (state == IDLE);
	assign ram_addr = (state == IDLE) ? load_addr : rd_addr;

	sample_ram #(
		.n_sample(n_sample)
	) u_sample_ram (
		.CLK  (CLK),
		.we   (ram_we),
		.addr (ram_addr),
		.wdata(load_data),
		.re   (rd_en),
		.rdata(ram_rdata)
	);

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state   <= IDLE;
			rd_pend <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (cmd_valid) begin
						if (cmd_kind == CMD_STREAM && cmd_wait) begin
							state <= WAIT_BOUNDARY;
						end else begin
							state <= READ;
						end
					end
				end
				WAIT_BOUNDARY: begin
					if (boundary_in) begin
						state <= READ;
					end
				end
				READ: begin
					if (rd_en && rd_left == count_t'(1)) begin
						state <= DRAIN;
					end
				end
				DRAIN: begin
					if (take && pkt_last) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase

			// RAM output register is the first item in flight
			if (rd_en) begin
				rd_pend <= 1'b1;
			end else if (move) begin
				rd_pend <= 1'b0;
			end
		end
	end

	// Command fields and the read address
	always_ff @(posedge CLK) begin
		if (accept) begin
			kind_q  <= cmd_kind;
			dest_q  <= cmd_dest;
			rd_addr <= cmd_start;
		end else if (rd_en) begin
			// Wrap at the block end for the circular stream
			rd_addr <= (rd_addr == saddr_t'(n_sample - 1)) ? '0 : rd_addr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			rd_left <= '0;
			rd_last <= 1'b0;
		end else if (accept) begin
			if (cmd_kind == CMD_STREAM) begin
				rd_left <= count_t'(n_sample);
			end else begin
				rd_left <= count_t'(cmd_stop) - count_t'(cmd_start) + 1'b1;
			end
		end else if (rd_en) begin
			rd_left <= rd_left - 1'b1;
			rd_last <= (rd_left == count_t'(1));
		end
	end

	//////////////////////////////////////////////////
	// Packet slot
	//////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			pkt_valid     <= 1'b0;
			pkt_last      <= 1'b0;
			boundary_next <= 1'b0;
		end else begin
			if (move) begin
				pkt_valid <= 1'b1;
				pkt_last  <= rd_last;
			end else if (take) begin
				pkt_valid <= 1'b0;
				pkt_last  <= 1'b0;
			end
			// Next lane may start once the last stream packet leaves
			boundary_next <= take && pkt_last && (kind_q == CMD_STREAM);
		end
	end

	always_ff @(posedge CLK) begin
		if (move) begin
			pkt <= make_packet(kind_pkt, lane_id, dest_q, ram_rdata);
		end
	end

	// A command for a busy lane would be lost
	a_cmd_idle: assert property (@(posedge CLK) disable iff (rst)
		cmd_valid |-> !busy);

	a_prefetch_range: assert property (@(posedge CLK) disable iff (rst)
		cmd_valid && cmd_kind == CMD_PREFETCH |->
			cmd_start <= cmd_stop && cmd_stop < n_sample);

endmodule

// ==== design/glob_dispatch.sv ====
`timescale 1ns/1ps

module glob_dispatch #(
	parameter int n_lanes = drbe_cfg_pkg::N_LANES
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    load_valid,
	input  drbe_cfg_pkg::lc_id_t    load_id,
	input  drbe_cfg_pkg::saddr_t    load_addr,
	input  drbe_cfg_pkg::sample_t   load_data,
	input  logic                    cmd_valid,
	input  drbe_cfg_pkg::lc_id_t    cmd_id,
	input  drbe_pkt_pkg::cmd_kind_e cmd_kind,
	input  drbe_cfg_pkg::saddr_t    cmd_start,
	input  drbe_cfg_pkg::saddr_t    cmd_stop,
	input  drbe_cfg_pkg::dest_t     cmd_dest,
	input  logic                    cmd_wait,
	output logic [n_lanes-1:0]      lane_load_valid,
	output drbe_cfg_pkg::saddr_t    lane_load_addr,
	output drbe_cfg_pkg::sample_t   lane_load_data,
	output logic [n_lanes-1:0]      lane_cmd_valid,
	output drbe_pkt_pkg::cmd_kind_e lane_cmd_kind,
	output drbe_cfg_pkg::saddr_t    lane_cmd_start,
	output drbe_cfg_pkg::saddr_t    lane_cmd_stop,
	output drbe_cfg_pkg::dest_t     lane_cmd_dest,
	output logic                    lane_cmd_wait
);
	import drbe_cfg_pkg::*;

	logic [n_lanes-1:0] load_hot;
	logic [n_lanes-1:0] cmd_hot;

	// Ids past the last lane match no bit
	always_comb begin
		for (int i = 0; i < n_lanes; i++) begin
			load_hot[i] = load_valid && (load_id == lc_id_t'(i));
			cmd_hot[i]  = cmd_valid && (cmd_id == lc_id_t'(i));
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			lane_load_valid <= '0;
			lane_cmd_valid  <= '0;
		end else begin
			lane_load_valid <= load_hot;
			lane_cmd_valid  <= cmd_hot;
		end
	end

	// Broadcast fields to every lane
	always_ff @(posedge CLK) begin
		if (load_valid) begin
			lane_load_addr <= load_addr;
			lane_load_data <= load_data;
		end
		if (cmd_valid) begin
			lane_cmd_kind  <= cmd_kind;
			lane_cmd_start <= cmd_start;
			lane_cmd_stop  <= cmd_stop;
			lane_cmd_dest  <= cmd_dest;
			lane_cmd_wait  <= cmd_wait;
		end
	end

	a_lane_strobe: assert property (@(posedge CLK) disable iff (rst)
		$onehot0(lane_load_valid) && $onehot0(lane_cmd_valid));

endmodule

// ==== design/packet_merge.sv ====
`timescale 1ns/1ps

module packet_merge #(
	parameter int n_lanes = drbe_cfg_pkg::N_LANES
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic [n_lanes-1:0]    lane_pkt_valid,
	input  drbe_pkt_pkg::packet_t lane_pkt [n_lanes],
	input  logic [n_lanes-1:0]    lane_last,
	output logic [n_lanes-1:0]    lane_take,
	output logic                  pkt_valid,
	output drbe_pkt_pkg::packet_t pkt_data,
	output logic                  pkt_last
);
	localparam int IDX_W = (n_lanes > 1) ? $clog2(n_lanes) : 1;

	logic [IDX_W-1:0] last_q;
	logic [IDX_W-1:0] sel;
	logic             found;

	//////////////////////////////////////////////////
	// Round-robin pick
	//////////////////////////////////////////////////

	// Search starts one past the last granted lane
	always_comb begin
		int idx;
		lane_take = '0;
		sel       = last_q;
		found     = 1'b0;
		for (int k = 1; k <= n_lanes; k++) begin
			idx = (int'(last_q) + k) % n_lanes;
			if (!found && lane_pkt_valid[idx]) begin
				lane_take[idx] = 1'b1;
				sel            = IDX_W'(idx);
				found          = 1'b1;
			end
		end
	end

	// Reset pointer at the top lane so lane 0 wins first
	always_ff @(posedge CLK) begin
		if (rst) begin
			pkt_valid <= 1'b0;
			pkt_last  <= 1'b0;
			last_q    <= IDX_W'(n_lanes - 1);
		end else begin
			pkt_valid <= found;
			pkt_last  <= found && lane_last[sel];
			if (found) begin
				last_q <= sel;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (found) begin
			pkt_data <= lane_pkt[sel];
		end
	end

	a_take_valid: assert property (@(posedge CLK) disable iff (rst)
		$onehot0(lane_take) && ((lane_take & ~lane_pkt_valid) == '0));

endmodule

// ==== design/drbe_array_top.sv ====
`timescale 1ns/1ps

module drbe_array_top #(
	parameter int n_lanes  = drbe_cfg_pkg::N_LANES,
	parameter int n_sample = drbe_cfg_pkg::N_SAMPLE
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    load_valid,
	input  drbe_cfg_pkg::lc_id_t    load_id,
	input  drbe_cfg_pkg::saddr_t    load_addr,
	input  drbe_cfg_pkg::sample_t   load_data,
	input  logic                    cmd_valid,
	input  drbe_cfg_pkg::lc_id_t    cmd_id,
	input  drbe_pkt_pkg::cmd_kind_e cmd_kind,
	input  drbe_cfg_pkg::saddr_t    cmd_start,
	input  drbe_cfg_pkg::saddr_t    cmd_stop,
	input  drbe_cfg_pkg::dest_t     cmd_dest,
	input  logic                    cmd_wait,
	input  logic                    boundary_in,
	output logic                    pkt_valid,
	output drbe_pkt_pkg::packet_t   pkt_data,
	output logic                    pkt_last,
	output logic [n_lanes-1:0]      busy
);
	import drbe_cfg_pkg::*;
	import drbe_pkt_pkg::*;

	logic [n_lanes-1:0] lane_load_valid;
	saddr_t             lane_load_addr;
	sample_t            lane_load_data;
	logic [n_lanes-1:0] lane_cmd_valid;
	cmd_kind_e          lane_cmd_kind;
	saddr_t             lane_cmd_start;
	saddr_t             lane_cmd_stop;
	dest_t              lane_cmd_dest;
	logic               lane_cmd_wait;
	logic [n_lanes-1:0] lane_bnd_in;
	logic [n_lanes-1:0] lane_bnd_next;
	logic [n_lanes-1:0] lane_pkt_valid;
	logic [n_lanes-1:0] lane_last;
	logic [n_lanes-1:0] lane_take;
	packet_t            lane_pkt [n_lanes];

	glob_dispatch #(
		.n_lanes(n_lanes)
	) u_glob_dispatch (
		.CLK            (CLK),
		.rst            (rst),
		.load_valid     (load_valid),
		.load_id        (load_id),
		.load_addr      (load_addr),
		.load_data      (load_data),
		.cmd_valid      (cmd_valid),
		.cmd_id         (cmd_id),
		.cmd_kind       (cmd_kind),
		.cmd_start      (cmd_start),
		.cmd_stop       (cmd_stop),
		.cmd_dest       (cmd_dest),
		.cmd_wait       (cmd_wait),
		.lane_load_valid(lane_load_valid),
		.lane_load_addr (lane_load_addr),
		.lane_load_data (lane_load_data),
		.lane_cmd_valid (lane_cmd_valid),
		.lane_cmd_kind  (lane_cmd_kind),
		.lane_cmd_start (lane_cmd_start),
		.lane_cmd_stop  (lane_cmd_stop),
		.lane_cmd_dest  (lane_cmd_dest),
		.lane_cmd_wait  (lane_cmd_wait)
	);

	//////////////////////////////////////////////////
	// Lanes and the boundary chain
	//////////////////////////////////////////////////

	for (genvar i = 0; i < n_lanes; i++) begin : g_lane
		// Lane 0 follows the outside boundary
		if (i == 0) begin : g_first
			assign lane_bnd_in[i] = boundary_in;
		end else begin : g_chain
			assign lane_bnd_in[i] = lane_bnd_next[i-1];
		end

		local_controller #(
			.n_sample(n_sample),
			.lane_id (lc_id_t'(i))
		) u_local_controller (
			.CLK          (CLK),
			.rst          (rst),
			.load_valid   (lane_load_valid[i]),
			.load_addr    (lane_load_addr),
			.load_data    (lane_load_data),
			.cmd_valid    (lane_cmd_valid[i]),
			.cmd_kind     (lane_cmd_kind),
			.cmd_start    (lane_cmd_start),
			.cmd_stop     (lane_cmd_stop),
			.cmd_dest     (lane_cmd_dest),
			.cmd_wait     (lane_cmd_wait),
			.boundary_in  (lane_bnd_in[i]),
			.take         (lane_take[i]),
			.pkt_valid    (lane_pkt_valid[i]),
			.pkt          (lane_pkt[i]),
			.pkt_last     (lane_last[i]),
			.boundary_next(lane_bnd_next[i]),
			.busy         (busy[i])
		);
	end

	packet_merge #(
		.n_lanes(n_lanes)
	) u_packet_merge (
		.CLK           (CLK),
		.rst           (rst),
		.lane_pkt_valid(lane_pkt_valid),
		.lane_pkt      (lane_pkt),
		.lane_last     (lane_last),
		.lane_take     (lane_take),
		.pkt_valid     (pkt_valid),
		.pkt_data      (pkt_data),
		.pkt_last      (pkt_last)
	);

endmodule

// ==== test/drbe_array_tb.sv ====
`timescale 1ns/1ps

module drbe_array_tb;
	import drbe_cfg_pkg::*;
	import drbe_pkt_pkg::*;

	localparam int NL       = N_LANES;
	localparam int NS       = N_SAMPLE;
	localparam int TIMEOUT  = 4000;
	// Packet field positions from the sample at the bottom up to the kind
	localparam int ID_LSB   = $bits(sample_t) + $bits(dest_t);
	localparam int KIND_BIT = ID_LSB + $bits(lc_id_t);

	logic          CLK;
	logic          rst;
	logic          load_valid;
	lc_id_t        load_id;
	saddr_t        load_addr;
	sample_t       load_data;
	logic          cmd_valid;
	lc_id_t        cmd_id;
	cmd_kind_e     cmd_kind;
	saddr_t        cmd_start;
	saddr_t        cmd_stop;
	dest_t         cmd_dest;
	logic          cmd_wait;
	logic          boundary_in;
	logic          pkt_valid;
	packet_t       pkt_data;
	logic          pkt_last;
	logic [NL-1:0] busy;

	integer        seed;
	int            cyc = 0;
	sample_t       model [NL][NS];
	packet_t       got_pkt [$];
	logic          got_last [$];
	int            got_cyc [$];
	int            lane_cnt [NL];
	int            fall_cnt [NL];
	logic [NL-1:0] busy_q;

	drbe_array_top #(
		.n_lanes (NL),
		.n_sample(NS)
	) u_drbe_array_top (
		.CLK        (CLK),
		.rst        (rst),
		.load_valid (load_valid),
		.load_id    (load_id),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.cmd_valid  (cmd_valid),
		.cmd_id     (cmd_id),
		.cmd_kind   (cmd_kind),
		.cmd_start  (cmd_start),
		.cmd_stop   (cmd_stop),
		.cmd_dest   (cmd_dest),
		.cmd_wait   (cmd_wait),
		.boundary_in(boundary_in),
		.pkt_valid  (pkt_valid),
		.pkt_data   (pkt_data),
		.pkt_last   (pkt_last),
		.busy       (busy)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("STATUS: FAIL");
			$fatal(1, "Run stopped");
		end
	end

	//////////////////////////////////////////////////
	// Output capture
	//////////////////////////////////////////////////

	always @(negedge CLK) begin
		int id;
		if (rst) begin
			busy_q = '0;
		end else begin
			if (pkt_valid) begin
				got_pkt.push_back(pkt_data);
				got_last.push_back(pkt_last);
				got_cyc.push_back(cyc);
				id = int'(pkt_data[ID_LSB +: $bits(lc_id_t)]);
				if (id < NL) lane_cnt[id]++;
			end
			// Packets seen when busy fell
			for (int i = 0; i < NL; i++) begin
				if (busy_q[i] && !busy[i]) fall_cnt[i] = lane_cnt[i];
			end
			busy_q = busy;
		end
	end

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("Error: time %0t signal %s expected %0h got %0h", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic clear_capture();
		got_pkt.delete();
		got_last.delete();
		got_cyc.delete();
		for (int i = 0; i < NL; i++) begin
			lane_cnt[i] = 0;
			fall_cnt[i] = -1;
		end
	endtask

	task automatic load_all();
		sample_t d;
		for (int l = 0; l < NL; l++) begin
			for (int a = 0; a < NS; a++) begin
				d = $random(seed);
				model[l][a] = d;
				@(posedge CLK);
				load_valid <= 1'b1;
				load_id    <= lc_id_t'(l);
				load_addr  <= saddr_t'(a);
				load_data  <= d;
			end
		end
	endtask

	task automatic send_cmd(input int lane, input cmd_kind_e kind, input int start,
			input int stop, input int dest, input logic wt);
		@(posedge CLK);
		cmd_valid <= 1'b1;
		cmd_id    <= lc_id_t'(lane);
		cmd_kind  <= kind;
		cmd_start <= saddr_t'(start);
		cmd_stop  <= saddr_t'(stop);
		cmd_dest  <= dest_t'(dest);
		cmd_wait  <= wt;
	endtask

	task automatic drop_strobes();
		@(posedge CLK);
		load_valid <= 1'b0;
		cmd_valid  <= 1'b0;
	endtask

	// Lanes idle and the merged output empty
	task automatic wait_done();
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		while (busy != '0 || pkt_valid) @(negedge CLK);
		@(posedge CLK);
	endtask

	// Expected samples run from start through start+count-1 and wrap at the block end
	task automatic check_lane(input int lane, input pkt_kind_e kind, input int start,
			input int count, input int dest);
		int      k;
		int      addr;
		packet_t p;
		k = 0;
		for (int j = 0; j < got_pkt.size(); j++) begin
			p = got_pkt[j];
			if (int'(p[ID_LSB +: $bits(lc_id_t)]) == lane) begin
				addr = (start + k) % NS;
				check("pkt kind", kind, p[KIND_BIT]);
				check("pkt dest", dest, p[$bits(sample_t) +: $bits(dest_t)]);
				check("pkt sample", model[lane][addr], p[$bits(sample_t)-1:0]);
				check("pkt_last", (k == count - 1), got_last[j]);
				k++;
			end
		end
		check("lane packet count", count, k);
	endtask

	function automatic int lane_cycle(input int lane, input logic first);
		int c;
		c = -1;
		for (int j = 0; j < got_pkt.size(); j++) begin
			if (int'(got_pkt[j][ID_LSB +: $bits(lc_id_t)]) == lane) begin
				if (!first || c < 0) c = got_cyc[j];
			end
		end
		return c;
	endfunction

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic idle_after_reset();
		repeat (5) begin
			@(negedge CLK);
			check("pkt_valid", 0, pkt_valid);
			check("pkt_last", 0, pkt_last);
			check("busy", 0, busy);
		end
	endtask

	task automatic stream_with_delay();
		clear_capture();
		for (int l = 0; l < NL; l++) begin
			send_cmd(l, CMD_STREAM, l * 4 + 3, 0, 8'h10 + l, 1'b0);
		end
		drop_strobes();
		wait_done();
		for (int l = 0; l < NL; l++) begin
			check_lane(l, PKT_STREAM, l * 4 + 3, NS, 8'h10 + l);
		end
		check("total packets", NL * NS, got_pkt.size());
	endtask

	// Prefetch with the wait flag set must start without a boundary
	task automatic prefetch_one_range();
		clear_capture();
		send_cmd(2, CMD_PREFETCH, 3, 9, 8'h40, 1'b1);
		drop_strobes();
		wait_done();
		check_lane(2, PKT_PREFETCH, 3, 7, 8'h40);
		check("total packets", 7, got_pkt.size());
	endtask

	task automatic chain_on_boundary();
		clear_capture();
		for (int l = 1; l < NL; l++) begin
			send_cmd(l, CMD_STREAM, l * 3, 0, 8'h20 + l, 1'b1);
		end
		send_cmd(0, CMD_STREAM, 0, 0, 8'h20, 1'b0);
		drop_strobes();
		wait_done();
		for (int l = 0; l < NL; l++) begin
			check_lane(l, PKT_STREAM, l * 3, NS, 8'h20 + l);
		end
		for (int l = 1; l < NL; l++) begin
			check("lane start after previous lane end", 1,
				lane_cycle(l, 1'b1) > lane_cycle(l - 1, 1'b0));
		end
	endtask

	task automatic ignore_bad_id();
		clear_capture();
		@(posedge CLK);
		load_valid <= 1'b1;
		load_id    <= lc_id_t'(NL);
		load_addr  <= '0;
		load_data  <= 32'hdeadbeef;
		send_cmd(NL, CMD_STREAM, 0, 0, 8'h55, 1'b0);
		send_cmd(15, CMD_PREFETCH, 0, 3, 8'h56, 1'b0);
		drop_strobes();
		repeat (30) @(negedge CLK);
		check("packets from invalid id", 0, got_pkt.size());
		check("busy", 0, busy);
	endtask

	task automatic prefetch_all_lanes();
		int lo [NL];
		int hi [NL];
		lo = '{0, 2, 5, 9};
		hi = '{15, 7, 14, 9};
		clear_capture();
		for (int l = 0; l < NL; l++) begin
			send_cmd(l, CMD_PREFETCH, lo[l], hi[l], 8'h30 + l, 1'b0);
		end
		drop_strobes();
		wait_done();
		for (int l = 0; l < NL; l++) begin
			check_lane(l, PKT_PREFETCH, lo[l], hi[l] - lo[l] + 1, 8'h30 + l);
			check("packets before busy fell", hi[l] - lo[l] + 1, fall_cnt[l]);
		end
		check("total packets", 33, got_pkt.size());
	endtask

	initial begin
		seed        = 32'hcccc;
		CLK         = 1'b0;
		rst         = 1'b1;
		load_valid  = 1'b0;
		load_id     = '0;
		load_addr   = '0;
		load_data   = '0;
		cmd_valid   = 1'b0;
		cmd_id      = '0;
		cmd_kind    = CMD_STREAM;
		cmd_start   = '0;
		cmd_stop    = '0;
		cmd_dest    = '0;
		cmd_wait    = 1'b0;
		boundary_in = 1'b0;
		clear_capture();
		repeat (10) @(posedge CLK);
		rst <= 1'b0;

		idle_after_reset();
		load_all();
		drop_strobes();
		stream_with_delay();
		prefetch_one_range();
		chain_on_boundary();
		ignore_bad_id();
		prefetch_all_lanes();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== drbe_array.f ====
design/drbe_cfg_pkg.sv
design/drbe_pkt_pkg.sv
design/sample_ram.sv
design/local_controller.sv
design/glob_dispatch.sv
design/packet_merge.sv
design/drbe_array_top.sv
test/drbe_array_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module drbe_array_tb \
		-f drbe_array.f -o drbe_array_sim
	./obj_dir/drbe_array_sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
